// File: hdl/rsa_settings.svh
`ifndef RSA_SETTINGS_SVH
`define RSA_SETTINGS_SVH

// operand size
`define RSA_WIDTH 256
`define RSA_WORDS (`RSA_WIDTH / 32)

// register map with one word every 4 bytes inside an operand block
`define ADDR_CTRL 12'h000
`define ADDR_STAT 12'h004
`define ADDR_N    12'h100
`define ADDR_D    12'h200
`define ADDR_A    12'h300
`define ADDR_R    12'h400

`endif

// File: hdl/apb_pkg.sv
package apb_pkg;

	// bus data word
	typedef logic [31:0] apb_word_t;

	// master to slave
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		apb_word_t   pwdata;
	} apb_req_t;

	// slave to master
	typedef struct packed {
		apb_word_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

endpackage

// File: hdl/rsa_pkg.sv
`include "rsa_settings.svh"

package rsa_pkg;

	// one big number
	typedef logic [`RSA_WIDTH-1:0] rsa_operand_t;

	// modulus and private exponent
	typedef struct packed {
		rsa_operand_t n;
		rsa_operand_t d;
	} rsa_key_t;

	// operands of one montgomery product
	typedef struct packed {
		rsa_operand_t a;
		rsa_operand_t b;
	} mont_req_t;

	// exponentiation controller
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREP,
		ST_ISSUE,
		ST_WAIT,
		ST_STEP
	} rsa_state_e;

endpackage

// File: hdl/rsa_prep.sv
`timescale 1ns/1ns

module rsa_prep (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_go,
	input  rsa_pkg::rsa_operand_t i_n,
	input  rsa_pkg::rsa_operand_t i_b,
	output rsa_pkg::rsa_operand_t o_m,
	output logic                  o_done
);
	import rsa_pkg::*;

	localparam int W  = $bits(rsa_operand_t);
	localparam int CW = $clog2(W + 1);

	logic          busy;
	logic [CW-1:0] cnt;
	rsa_operand_t  n_q;
	rsa_operand_t  acc;
	logic [W:0]    dbl;
	logic [W:0]    red;

	// value stays below n, so doubling needs only one extra bit
	assign dbl = {acc, 1'b0};
	assign red = dbl - {1'b0, n_q};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			busy   <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_go) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				if (cnt == CW'(W)) begin
					busy   <= 1'b0;
					o_done <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_go) begin
			n_q <= i_n;
			acc <= i_b;
		end else if (busy) begin
			if (cnt == CW'(W)) begin
				o_m <= acc;
			end else if (dbl >= {1'b0, n_q}) begin
				acc <= red[W-1:0];
			end else begin
				acc <= dbl[W-1:0];
			end
		end
	end

endmodule

// File: hdl/rsa_mont.sv
`timescale 1ns/1ns

module rsa_mont (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_go,
	input  rsa_pkg::rsa_operand_t i_n,
	input  rsa_pkg::mont_req_t    i_req,
	output rsa_pkg::rsa_operand_t o_m,
	output logic                  o_done
);
	import rsa_pkg::*;

	localparam int W  = $bits(rsa_operand_t);
	localparam int CW = $clog2(W + 1);

	logic          busy;
	logic [CW-1:0] cnt;
	rsa_operand_t  n_q;
	rsa_operand_t  a_q;
	rsa_operand_t  b_q;
	logic [W:0]    acc;
	logic [W+1:0]  sum_b;
	logic [W+1:0]  sum_n;
	logic [W:0]    diff;

	// acc stays below 2n, so acc + b + n fits in W+2 bits
	assign sum_b = {1'b0, acc} + (a_q[0] ? {2'b00, b_q} : '0);
	// make it even before halving
	assign sum_n = sum_b[0] ? sum_b + {2'b00, n_q} : sum_b;
	assign diff  = acc - {1'b0, n_q};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			busy   <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_go) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				if (cnt == CW'(W)) begin
					busy   <= 1'b0;
					o_done <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_go) begin
			n_q <= i_n;
			a_q <= i_req.a;
			b_q <= i_req.b;
			acc <= '0;
		end else if (busy) begin
			if (cnt == CW'(W)) begin
				// final correction into [0, n)
				o_m <= (acc >= {1'b0, n_q}) ? diff[W-1:0] : acc[W-1:0];
			end else begin
				acc <= sum_n[W+1:1];
				a_q <= a_q >> 1;
			end
		end
	end

endmodule

// File: hdl/rsa_core.sv
`timescale 1ns/1ns

module rsa_core (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_start,
	input  rsa_pkg::rsa_key_t     i_key,
	input  rsa_pkg::rsa_operand_t i_a,
	output rsa_pkg::rsa_operand_t o_result,
	output logic                  o_done
);
	import rsa_pkg::*;

	localparam int W  = $bits(rsa_operand_t);
	localparam int IW = $clog2(W);

	rsa_state_e    state;
	logic [IW-1:0] idx;
	logic          d_bit;
	logic          prep_go;
	logic          sqr_go;
	logic          acc_go;
	logic          prep_done;
	logic          sqr_done;
	logic          acc_done;
	logic          sqr_fin;
	logic          acc_fin;
	rsa_operand_t  prep_m;
	rsa_operand_t  sqr_m;
	rsa_operand_t  acc_m;
	rsa_operand_t  t;
	rsa_operand_t  result;
	mont_req_t     sqr_req;
	mont_req_t     acc_req;

	// exponent scanned lsb first
	assign d_bit    = i_key.d[idx];
	assign sqr_req  = '{a: t, b: t};
	assign acc_req  = '{a: result, b: t};
	assign o_result = result;

	rsa_prep u_prep (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_go   (prep_go),
		.i_n    (i_key.n),
		.i_b    (i_a),
		.o_m    (prep_m),
		.o_done (prep_done)
	);

	rsa_mont u_mont_sqr (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_go   (sqr_go),
		.i_n    (i_key.n),
		.i_req  (sqr_req),
		.o_m    (sqr_m),
		.o_done (sqr_done)
	);

	rsa_mont u_mont_acc (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_go   (acc_go),
		.i_n    (i_key.n),
		.i_req  (acc_req),
		.o_m    (acc_m),
		.o_done (acc_done)
	);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state   <= ST_IDLE;
			idx     <= '0;
			prep_go <= 1'b0;
			sqr_go  <= 1'b0;
			acc_go  <= 1'b0;
			sqr_fin <= 1'b0;
			acc_fin <= 1'b0;
			o_done  <= 1'b0;
		end else begin
			prep_go <= 1'b0;
			sqr_go  <= 1'b0;
			acc_go  <= 1'b0;
			o_done  <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						prep_go <= 1'b1;
						state   <= ST_PREP;
					end
				end
				ST_PREP: begin
					if (prep_done) begin
						idx   <= '0;
						state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					sqr_go  <= 1'b1;
					acc_go  <= d_bit;
					sqr_fin <= 1'b0;
					// skipped multiply counts as finished
					acc_fin <= !d_bit;
					state   <= ST_WAIT;
				end
				ST_WAIT: begin
					if (sqr_done) begin
						sqr_fin <= 1'b1;
					end
					if (acc_done) begin
						acc_fin <= 1'b1;
					end
					if (sqr_fin && acc_fin) begin
						state <= ST_STEP;
					end
				end
				ST_STEP: begin
					if (idx == IW'(W - 1)) begin
						o_done <= 1'b1;
						state  <= ST_IDLE;
					end else begin
						idx   <= idx + 1'b1;
						state <= ST_ISSUE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// t in montgomery domain, result in normal domain starting at 1
	always_ff @(posedge i_clk) begin
		if (state == ST_PREP && prep_done) begin
			t      <= prep_m;
			result <= rsa_operand_t'(1);
		end else if (state == ST_WAIT && sqr_fin && acc_fin) begin
			t <= sqr_m;
			if (d_bit) begin
				result <= acc_m;
			end
		end
	end

endmodule

// File: hdl/rsa_apb_regs.sv
`timescale 1ns/1ns
`include "rsa_settings.svh"

module rsa_apb_regs (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  apb_pkg::apb_req_t     i_apb,
	output apb_pkg::apb_rsp_t     o_apb,
	output logic                  o_start,
	output rsa_pkg::rsa_key_t     o_key,
	output rsa_pkg::rsa_operand_t o_a,
	input  rsa_pkg::rsa_operand_t i_result,
	input  logic                  i_done
);
	import apb_pkg::*;
	import rsa_pkg::*;

	logic         access;
	logic         wr_ok;
	logic [11:0]  base;
	logic [7:0]   off;
	logic [5:0]   word;
	logic         word_ok;
	logic         hit_ctrl;
	logic         hit_stat;
	logic         hit_n;
	logic         hit_d;
	logic         hit_a;
	logic         hit_r;
	logic         hit_op;
	logic         err;
	logic         busy;
	logic         done;
	rsa_operand_t result_q;
	apb_word_t    rdata;

	assign access = i_apb.psel && i_apb.penable;

	// block select from the upper nibble, word index below it
	assign base     = {i_apb.paddr[11:8], 8'h00};
	assign off      = i_apb.paddr[7:0];
	assign word     = off[7:2];
	assign word_ok  = (off[1:0] == 2'b00) && (word < 6'(`RSA_WORDS));
	assign hit_ctrl = i_apb.paddr == `ADDR_CTRL;
	assign hit_stat = i_apb.paddr == `ADDR_STAT;
	assign hit_n    = (base == `ADDR_N) && word_ok;
	assign hit_d    = (base == `ADDR_D) && word_ok;
	assign hit_a    = (base == `ADDR_A) && word_ok;
	assign hit_r    = (base == `ADDR_R) && word_ok;
	assign hit_op   = hit_n || hit_d || hit_a;

	always_comb begin
		err = !(hit_ctrl || hit_stat || hit_op || hit_r);
		if (i_apb.pwrite) begin
			// read-only registers
			if (hit_stat || hit_r) begin
				err = 1'b1;
			end
			// operands are locked while the core runs
			if (busy && (hit_op || (hit_ctrl && i_apb.pwdata[0]))) begin
				err = 1'b1;
			end
		end
	end

	assign wr_ok = access && i_apb.pwrite && !err;

	always_comb begin
		rdata = '0;
		if (hit_stat) begin
			rdata = {30'd0, done, busy};
		end else if (hit_n) begin
			rdata = o_key.n[word*32 +: 32];
		end else if (hit_d) begin
			rdata = o_key.d[word*32 +: 32];
		end else if (hit_a) begin
			rdata = o_a[word*32 +: 32];
		end else if (hit_r) begin
			rdata = result_q[word*32 +: 32];
		end
	end

	// no wait states
	assign o_apb = '{prdata: rdata, pready: 1'b1, pslverr: access && err};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_start  <= 1'b0;
			busy     <= 1'b0;
			done     <= 1'b0;
			result_q <= '0;
		end else begin
			o_start <= 1'b0;
			if (wr_ok && hit_ctrl && i_apb.pwdata[0]) begin
				o_start <= 1'b1;
				busy    <= 1'b1;
				done    <= 1'b0;
			end else if (i_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (i_done) begin
				result_q <= i_result;
			end
		end
	end

	// operand words
	always_ff @(posedge i_clk) begin
		if (wr_ok && hit_n) begin
			o_key.n[word*32 +: 32] <= i_apb.pwdata;
		end
		if (wr_ok && hit_d) begin
			o_key.d[word*32 +: 32] <= i_apb.pwdata;
		end
		if (wr_ok && hit_a) begin
			o_a[word*32 +: 32] <= i_apb.pwdata;
		end
	end

endmodule

// File: hdl/rsa_top.sv
`timescale 1ns/1ns

module rsa_top (
	input  logic              i_clk,
	input  logic              i_rst,
	input  apb_pkg::apb_req_t i_apb,
	output apb_pkg::apb_rsp_t o_apb
);
	import rsa_pkg::*;

	logic         start;
	logic         done;
	rsa_key_t     key;
	rsa_operand_t base;
	rsa_operand_t result;

	// host side registers
	rsa_apb_regs u_regs (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_apb    (i_apb),
		.o_apb    (o_apb),
		.o_start  (start),
		.o_key    (key),
		.o_a      (base),
		.i_result (result),
		.i_done   (done)
	);

	// exponentiation engine
	rsa_core u_core (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (start),
		.i_key    (key),
		.i_a      (base),
		.o_result (result),
		.o_done   (done)
	);

endmodule

// File: tests/rsa_tb.sv
`timescale 1ns/1ns
`include "rsa_settings.svh"

module rsa_tb;
	import apb_pkg::*;
	import rsa_pkg::*;

	localparam int W            = `RSA_WIDTH;
	localparam int NUM_HAND     = 4;
	localparam int NUM_VEC      = 6;
	localparam int PREADY_LIMIT = 16;
	localparam int POLL_LIMIT   = 50000;

	// one table row with key, base and expected a^d mod n
	typedef struct packed {
		rsa_operand_t n;
		rsa_operand_t d;
		rsa_operand_t a;
		rsa_operand_t r;
	} vector_t;

	logic     clk;
	logic     rst;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	vector_t  vectors [NUM_VEC];

	rsa_top i_rsa_top (
		.i_clk (clk),
		.i_rst (rst),
		.i_apb (apb_req),
		.o_apb (apb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic report_error(input string msg);
		abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
	endtask

	task automatic check_operand(input string what, input rsa_operand_t got,
	                             input rsa_operand_t exp);
		if (got !== exp) begin
			report_error($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	task automatic check_word(input string what, input apb_word_t got, input apb_word_t exp);
		if (got !== exp) begin
			report_error($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	task automatic check_slverr(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			report_error($sformatf("%s pslverr got %b expected %b", what, got, exp));
		end
	endtask

	// reference model using plain square-and-multiply in double width
	function automatic rsa_operand_t mod_exp(input rsa_operand_t n, input rsa_operand_t d,
	                                         input rsa_operand_t a);
		logic [2*W-1:0] nn;
		logic [2*W-1:0] sq;
		logic [2*W-1:0] acc;
		nn  = {{W{1'b0}}, n};
		sq  = {{W{1'b0}}, a} % nn;
		acc = 1;
		for (int i = 0; i < W; i++) begin
			if (d[i]) begin
				acc = (acc * sq) % nn;
			end
			sq = (sq * sq) % nn;
		end
		return acc[W-1:0];
	endfunction

	function automatic rsa_operand_t rand_operand();
		rsa_operand_t v;
		for (int i = 0; i < `RSA_WORDS; i++) begin
			v[i*32 +: 32] = $urandom();
		end
		return v;
	endfunction

	task automatic build_vectors();
		rsa_operand_t n;
		// textbook keys, then d = 0 and d = 1
		vectors[0] = '{n: 3233, d: 2753, a: 2790, r: 65};
		vectors[1] = '{n: 187, d: 23, a: 11, r: 88};
		vectors[2] = '{n: 3233, d: 0, a: 1234, r: 1};
		vectors[3] = '{n: 3233, d: 1, a: 1234, r: 1234};
		for (int i = NUM_HAND; i < NUM_VEC; i++) begin
			n        = rand_operand();
			n[W-1]   = 1'b1;
			n[0]     = 1'b1;
			vectors[i].n = n;
			vectors[i].d = rand_operand();
			vectors[i].a = rand_operand() % n;
			vectors[i].r = mod_exp(n, vectors[i].d, vectors[i].a);
		end
	endtask

	// setup and access phase with the response sampled on the falling edge
	task automatic apb_xfer(input logic write, input logic [11:0] addr, input apb_word_t wdata,
	                        output apb_word_t rdata, output logic slverr);
		int unsigned cycles;
		cycles = 0;
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		@(negedge clk);
		while (apb_rsp.pready !== 1'b1) begin
			if (cycles == PREADY_LIMIT) begin
				abort_run("APB transfer timed out waiting for pready");
			end
			cycles++;
			@(negedge clk);
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input apb_word_t data,
	                         input logic exp_err, input string what);
		apb_word_t rd;
		logic      err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_slverr(what, err, exp_err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output apb_word_t data,
	                        input logic exp_err, input string what);
		logic err;
		apb_xfer(1'b0, addr, '0, data, err);
		check_slverr(what, err, exp_err);
	endtask

	task automatic write_operand(input logic [11:0] base, input rsa_operand_t v);
		for (int i = 0; i < `RSA_WORDS; i++) begin
			apb_write(base + 12'(4 * i), v[i*32 +: 32], 1'b0, "operand write");
		end
	endtask

	task automatic read_operand(input logic [11:0] base, output rsa_operand_t v);
		apb_word_t w;
		for (int i = 0; i < `RSA_WORDS; i++) begin
			apb_read(base + 12'(4 * i), w, 1'b0, "operand read");
			v[i*32 +: 32] = w;
		end
	endtask

	task automatic check_reset_state();
		apb_word_t w;
		apb_read(`ADDR_STAT, w, 1'b0, "status read");
		check_word("status after reset", w, 32'h0);
		for (int i = 0; i < `RSA_WORDS; i++) begin
			apb_read(`ADDR_R + 12'(4 * i), w, 1'b0, "result read");
			check_word("result word after reset", w, 32'h0);
		end
	endtask

	task automatic check_operands(input vector_t vec);
		rsa_operand_t v;
		read_operand(`ADDR_N, v);
		check_operand("N readback", v, vec.n);
		read_operand(`ADDR_D, v);
		check_operand("d readback", v, vec.d);
		read_operand(`ADDR_A, v);
		check_operand("a readback", v, vec.a);
	endtask

	task automatic run_vector(input vector_t vec, input bit probe_busy);
		apb_word_t    stat;
		rsa_operand_t got;
		int unsigned  polls;
		write_operand(`ADDR_N, vec.n);
		write_operand(`ADDR_D, vec.d);
		write_operand(`ADDR_A, vec.a);
		apb_write(`ADDR_CTRL, 32'h1, 1'b0, "start");
		// done from the previous run must be gone
		apb_read(`ADDR_STAT, stat, 1'b0, "status read");
		check_word("status after start", stat, 32'h1);
		if (probe_busy) begin
			apb_write(`ADDR_N, ~vec.n[31:0], 1'b1, "N write while busy");
			apb_write(`ADDR_D + 12'h4, 32'hdead_beef, 1'b1, "d write while busy");
			apb_write(`ADDR_A, 32'h1234_5678, 1'b1, "a write while busy");
			apb_write(`ADDR_CTRL, 32'h1, 1'b1, "start while busy");
		end
		polls = 0;
		apb_read(`ADDR_STAT, stat, 1'b0, "status read");
		while (!stat[1]) begin
			check_word("status while busy", stat, 32'h1);
			if (polls == POLL_LIMIT) begin
				abort_run("core did not raise done within the status poll limit");
			end
			polls++;
			apb_read(`ADDR_STAT, stat, 1'b0, "status read");
		end
		check_word("status after done", stat, 32'h2);
		read_operand(`ADDR_R, got);
		check_operand("result", got, vec.r);
		if (probe_busy) begin
			check_operands(vec);
		end
	endtask

	task automatic check_decode_errors(input vector_t vec);
		apb_word_t    w;
		rsa_operand_t got;
		apb_read(12'h008, w, 1'b1, "read of unmapped address");
		apb_write(12'h500, 32'h1, 1'b1, "write to unmapped block");
		apb_write(`ADDR_N + 12'h20, 32'h1, 1'b1, "write past last N word");
		apb_write(`ADDR_A + 12'h2, 32'h1, 1'b1, "misaligned a write");
		apb_write(`ADDR_STAT, 32'h0, 1'b1, "status write");
		apb_write(`ADDR_R, 32'h0, 1'b1, "result write");
		// nothing above may have landed
		check_operands(vec);
		apb_read(`ADDR_STAT, w, 1'b0, "status read");
		check_word("status after rejected writes", w, 32'h2);
		read_operand(`ADDR_R, got);
		check_operand("result after rejected writes", got, vec.r);
	endtask

	initial begin
		void'($urandom(32'h96f8_c559));
		rst     = 1'b0;
		apb_req = '0;
		build_vectors();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b1;
		check_reset_state();
		for (int i = 0; i < NUM_VEC; i++) begin
			run_vector(vectors[i], i == 1);
			if (i == 0) begin
				check_decode_errors(vectors[0]);
			end
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: project.f
+incdir+hdl
hdl/apb_pkg.sv
hdl/rsa_pkg.sv
hdl/rsa_prep.sv
hdl/rsa_mont.sv
hdl/rsa_core.sv
hdl/rsa_apb_regs.sv
hdl/rsa_top.sv
tests/rsa_tb.sv

// File: Bender.yml
package:
  name: rsa_modexp

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/apb_pkg.sv
      - hdl/rsa_pkg.sv
      - hdl/rsa_prep.sv
      - hdl/rsa_mont.sv
      - hdl/rsa_core.sv
      - hdl/rsa_apb_regs.sv
      - hdl/rsa_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/rsa_tb.sv
